// File: design/video_pkg.sv
package video_pkg;

////////////////////////////////////////
// Widths
////////////////////////////////////////
localparam int COORD_W = 12;    // Raster counters and timing words
localparam int COLOR_W = 8;     // One colour channel
localparam int SYNTH_W = 8;     // Synthesizer multiply and divide values

localparam int DEBOUNCE_CYCLES = 16;    // Switch must hold this long
localparam int DEBOUNCE_W = $clog2(DEBOUNCE_CYCLES + 1);

////////////////////////////////////////
// Video modes
////////////////////////////////////////
typedef enum logic [1:0] {
	HMD = 2'd0,    // 1440x900
	XGA = 2'd1,    // 1024x768
	FHD = 2'd2     // 1920x1080
} mode_t;

// Tables below are indexed by mode, entry 3 repeats HMD

// Horizontal timing
localparam logic [COORD_W-1:0] HPIXELS [4] = '{12'd1440, 12'd1024, 12'd1920, 12'd1440};
localparam logic [COORD_W-1:0] HFPORCH [4] = '{12'd80, 12'd24, 12'd88, 12'd80};
localparam logic [COORD_W-1:0] HSYNCPW [4] = '{12'd152, 12'd136, 12'd44, 12'd152};
localparam logic [COORD_W-1:0] HBPORCH [4] = '{12'd232, 12'd160, 12'd148, 12'd232};

// Vertical timing, in lines
localparam logic [COORD_W-1:0] VLINES  [4] = '{12'd900, 12'd768, 12'd1080, 12'd900};
localparam logic [COORD_W-1:0] VFPORCH [4] = '{12'd1, 12'd3, 12'd4, 12'd1};
localparam logic [COORD_W-1:0] VSYNCPW [4] = '{12'd3, 12'd6, 12'd5, 12'd3};
localparam logic [COORD_W-1:0] VBPORCH [4] = '{12'd28, 12'd29, 12'd36, 12'd28};

localparam logic [3:0] SYNC_POSITIVE = 4'b1111;    // One bit per mode

////////////////////////////////////////
// Pixel clock synthesizer
////////////////////////////////////////
// Stored as value minus one, the way the synthesizer is programmed
localparam logic [SYNTH_W-1:0] SYNTH_M [4] = '{
	8'd180,    // 106.47 MHz
	8'd81,     // 65 MHz
	8'd198,    // 148.5 MHz
	8'd180
};
localparam logic [SYNTH_W-1:0] SYNTH_D [4] = '{
	8'd84,
	8'd62,
	8'd66,
	8'd84
};

////////////////////////////////////////
// Colour bars
////////////////////////////////////////
localparam logic [COLOR_W-1:0] COLOR_FULL = 8'hC0;    // 75 percent level
localparam logic [COLOR_W-1:0] COLOR_NONE = 8'h00;

localparam logic [COORD_W-1:0] BAR_WIDTH [4] = '{
	HPIXELS[0] / 8,
	HPIXELS[1] / 8,
	HPIXELS[2] / 8,
	HPIXELS[3] / 8
};

// Packed as red, green, blue
localparam logic [3*COLOR_W-1:0] BAR_COLORS [8] = '{
	{COLOR_FULL, COLOR_FULL, COLOR_FULL},    // White
	{COLOR_FULL, COLOR_FULL, COLOR_NONE},    // Yellow
	{COLOR_NONE, COLOR_FULL, COLOR_FULL},    // Cyan
	{COLOR_NONE, COLOR_FULL, COLOR_NONE},    // Green
	{COLOR_FULL, COLOR_NONE, COLOR_FULL},    // Magenta
	{COLOR_FULL, COLOR_NONE, COLOR_NONE},    // Red
	{COLOR_NONE, COLOR_NONE, COLOR_FULL},    // Blue
	{COLOR_NONE, COLOR_NONE, COLOR_NONE}     // Black
};

endpackage

// File: design/mode_select.sv
`timescale 1ns/1ps

module mode_select (
	input  logic                          clk50m_bufg,
	input  logic                          reset,
	input  logic [1:0]                    sw,
	output video_pkg::mode_t              mode,
	output logic                          restart,
	output logic [video_pkg::SYNTH_W-1:0] pclk_m,
	output logic [video_pkg::SYNTH_W-1:0] pclk_d
);

logic [1:0] sw_meta;    // First synchronizer stage
logic [1:0] sw_sync;
video_pkg::mode_t sw_mode;
video_pkg::mode_t candidate;    // Value being debounced
logic [video_pkg::DEBOUNCE_W-1:0] stable_cnt;
logic accept;

////////////////////////////////////////
// Synchronizer
////////////////////////////////////////
always_ff @(posedge clk50m_bufg) begin
	if (reset) begin
		sw_meta <= 2'b00;
		sw_sync <= 2'b00;
	end else begin
		sw_meta <= sw;
		sw_sync <= sw_meta;
	end
end

always_comb begin
	if (sw_sync == 2'd3) begin
		sw_mode = video_pkg::HMD;    // Unused code falls back
	end else begin
		sw_mode = video_pkg::mode_t'(sw_sync);
	end
end

////////////////////////////////////////
// Debounce
////////////////////////////////////////
always_ff @(posedge clk50m_bufg) begin
	if (reset) begin
		candidate  <= video_pkg::HMD;
		stable_cnt <= '0;
	end else if (sw_mode != candidate) begin
		candidate  <= sw_mode;    // Start over on any change
		stable_cnt <= 1'b1;
	end else if (stable_cnt != video_pkg::DEBOUNCE_CYCLES) begin
		stable_cnt <= stable_cnt + 1'b1;
	end
end

assign accept = (stable_cnt == video_pkg::DEBOUNCE_CYCLES) &&
		(sw_mode == candidate) && (candidate != mode);

// Mode latch and synthesizer values
always_ff @(posedge clk50m_bufg) begin
	if (reset) begin
		mode    <= video_pkg::HMD;
		restart <= 1'b0;
		pclk_m  <= video_pkg::SYNTH_M[video_pkg::HMD];
		pclk_d  <= video_pkg::SYNTH_D[video_pkg::HMD];
	end else begin
		restart <= accept;    // Single pulse, mode differs next cycle
		if (accept) begin
			mode   <= candidate;
			pclk_m <= video_pkg::SYNTH_M[candidate];
			pclk_d <= video_pkg::SYNTH_D[candidate];
		end
	end
end

endmodule

// File: design/raster_counter.sv
`timescale 1ns/1ps

module raster_counter (
	input  logic                          clk50m_bufg,
	input  logic                          reset,
	input  video_pkg::mode_t              mode,
	input  logic                          restart,
	output logic [video_pkg::COORD_W-1:0] hcount,
	output logic [video_pkg::COORD_W-1:0] vcount,
	output logic                          hsync_raw,
	output logic                          vsync_raw,
	output logic                          active
);

logic [video_pkg::COORD_W-1:0] h_total;     // Clocks per line
logic [video_pkg::COORD_W-1:0] hs_start;
logic [video_pkg::COORD_W-1:0] hs_end;
logic [video_pkg::COORD_W-1:0] v_total;     // Lines per frame
logic [video_pkg::COORD_W-1:0] vs_start;
logic [video_pkg::COORD_W-1:0] vs_end;
logic h_last;
logic v_last;

////////////////////////////////////////
// Mode timing
////////////////////////////////////////
assign hs_start = video_pkg::HPIXELS[mode] + video_pkg::HFPORCH[mode];
assign hs_end   = hs_start + video_pkg::HSYNCPW[mode];
assign h_total  = hs_end + video_pkg::HBPORCH[mode];

assign vs_start = video_pkg::VLINES[mode] + video_pkg::VFPORCH[mode];
assign vs_end   = vs_start + video_pkg::VSYNCPW[mode];
assign v_total  = vs_end + video_pkg::VBPORCH[mode];

// Greater-or-equal also catches a count left over from a longer mode
assign h_last = (hcount >= h_total - 1'b1);
assign v_last = (vcount >= v_total - 1'b1);

////////////////////////////////////////
// Counters
////////////////////////////////////////
always_ff @(posedge clk50m_bufg) begin
	if (reset || restart) begin
		hcount <= '0;
		vcount <= '0;
	end else if (h_last) begin
		hcount <= '0;
		if (v_last) begin
			vcount <= '0;    // End of frame
		end else begin
			vcount <= vcount + 1'b1;
		end
	end else begin
		hcount <= hcount + 1'b1;
	end
end

////////////////////////////////////////
// Window decode
////////////////////////////////////////
// Line layout is active, front porch, sync, back porch
assign active    = (hcount < video_pkg::HPIXELS[mode]) &&
		(vcount < video_pkg::VLINES[mode]);
assign hsync_raw = (hcount >= hs_start) && (hcount < hs_end);
assign vsync_raw = (vcount >= vs_start) && (vcount < vs_end);

endmodule

// File: design/sync_gen.sv
`timescale 1ns/1ps

module sync_gen (
	input  logic             clk50m_bufg,
	input  logic             reset,
	input  video_pkg::mode_t mode,
	input  logic             hsync_raw,
	input  logic             vsync_raw,
	input  logic             active,
	output logic             hsync,
	output logic             vsync,
	output logic             de
);

logic polarity;    // High for positive sync
logic hsync_q;
logic vsync_q;
logic de_q;

assign polarity = video_pkg::SYNC_POSITIVE[mode];

always_ff @(posedge clk50m_bufg) begin
	if (reset) begin
		hsync_q <= ~polarity;    // Inactive level
		vsync_q <= ~polarity;
		de_q    <= 1'b0;
		hsync   <= ~polarity;
		vsync   <= ~polarity;
		de      <= 1'b0;
	end else begin
		hsync_q <= hsync_raw ~^ polarity;    // Invert for negative sync
		vsync_q <= vsync_raw ~^ polarity;
		de_q    <= active;
		hsync   <= hsync_q;
		vsync   <= vsync_q;
		de      <= de_q;
	end
end

endmodule

// File: design/color_bar_gen.sv
`timescale 1ns/1ps

module color_bar_gen (
	input  logic                          clk50m_bufg,
	input  logic                          reset,
	input  video_pkg::mode_t              mode,
	input  logic [video_pkg::COORD_W-1:0] hcount,
	output logic [video_pkg::COLOR_W-1:0] red,
	output logic [video_pkg::COLOR_W-1:0] green,
	output logic [video_pkg::COLOR_W-1:0] blue
);

logic [2:0] bar_next;
logic [2:0] bar_idx;    // Stage one result
logic [video_pkg::COORD_W-1:0] bar_edge;

////////////////////////////////////////
// Stage one, bar index
////////////////////////////////////////
// Count bar edges passed instead of dividing
always_comb begin
	bar_next = '0;
	bar_edge = video_pkg::BAR_WIDTH[mode];
	for (int k = 0; k < 7; k++) begin
		if (hcount >= bar_edge) begin
			bar_next = bar_next + 1'b1;
		end
		bar_edge = bar_edge + video_pkg::BAR_WIDTH[mode];
	end
end

always_ff @(posedge clk50m_bufg) begin
	if (reset) begin
		bar_idx <= '0;
	end else begin
		bar_idx <= bar_next;    // Saturates at 7 in blanking
	end
end

////////////////////////////////////////
// Stage two, colour lookup
////////////////////////////////////////
always_ff @(posedge clk50m_bufg) begin
	if (reset) begin
		red   <= '0;
		green <= '0;
		blue  <= '0;
	end else begin
		{red, green, blue} <= video_pkg::BAR_COLORS[bar_idx];
	end
end

endmodule

// File: design/video_timing_top.sv
`timescale 1ns/1ps

module video_timing_top (
	input  logic                          clk50m_bufg,
	input  logic                          reset,
	input  logic [1:0]                    sw,
	output logic [video_pkg::SYNTH_W-1:0] pclk_m,
	output logic [video_pkg::SYNTH_W-1:0] pclk_d,
	output logic                          hsync,
	output logic                          vsync,
	output logic                          de,
	output logic [video_pkg::COLOR_W-1:0] red,
	output logic [video_pkg::COLOR_W-1:0] green,
	output logic [video_pkg::COLOR_W-1:0] blue
);

video_pkg::mode_t mode;
logic restart;    // First cycle of a new mode
logic [video_pkg::COORD_W-1:0] hcount;
logic hsync_raw;
logic vsync_raw;
logic active;

mode_select mode_select_0 (
	.clk50m_bufg (clk50m_bufg),
	.reset       (reset),
	.sw          (sw),
	.mode        (mode),
	.restart     (restart),
	.pclk_m      (pclk_m),
	.pclk_d      (pclk_d)
);

raster_counter raster_counter_0 (
	.clk50m_bufg (clk50m_bufg),
	.reset       (reset),
	.mode        (mode),
	.restart     (restart),
	.hcount      (hcount),
	.vcount      (),
	.hsync_raw   (hsync_raw),
	.vsync_raw   (vsync_raw),
	.active      (active)
);

// Both branches below add two cycles, so pixel and de stay aligned
sync_gen sync_gen_0 (
	.clk50m_bufg (clk50m_bufg),
	.reset       (reset),
	.mode        (mode),
	.hsync_raw   (hsync_raw),
	.vsync_raw   (vsync_raw),
	.active      (active),
	.hsync       (hsync),
	.vsync       (vsync),
	.de          (de)
);

color_bar_gen color_bar_gen_0 (
	.clk50m_bufg (clk50m_bufg),
	.reset       (reset),
	.mode        (mode),
	.hcount      (hcount),
	.red         (red),
	.green       (green),
	.blue        (blue)
);

endmodule

// File: sim/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
	output logic clk50m_bufg,
	output logic reset
);

localparam int RESET_CYCLES = 10;

initial begin
	clk50m_bufg = 1'b0;
	forever #10 clk50m_bufg = ~clk50m_bufg;    // 20 ns period
end

initial begin
	reset = 1'b1;
	repeat (RESET_CYCLES) @(posedge clk50m_bufg);
	reset <= 1'b0;    // Released on a rising edge
end

endmodule

// File: sim/video_timing_assertions.sv
`timescale 1ns/1ps

module video_timing_assertions (
	input logic                          clk50m_bufg,
	input logic                          reset,
	input video_pkg::mode_t              mode,
	input logic                          restart,
	input logic [video_pkg::COORD_W-1:0] hcount,
	input logic                          hsync_raw,
	input logic                          active
);

int fail_count = 0;    // Read by the testbench
logic [video_pkg::COORD_W-1:0] line_total;

assign line_total = video_pkg::HPIXELS[mode] + video_pkg::HFPORCH[mode] +
		video_pkg::HSYNCPW[mode] + video_pkg::HBPORCH[mode];

// The restart cycle may still carry a count from the previous mode
hcount_in_line: assert property (@(posedge clk50m_bufg) disable iff (reset)
		!restart |-> (hcount < line_total))
	else begin
		fail_count++;
		$error("hcount %0d is not below the line total %0d", hcount, line_total);
	end

restart_clears: assert property (@(posedge clk50m_bufg) disable iff (reset)
		restart |=> (hcount == '0))
	else begin
		fail_count++;
		$error("hcount did not return to zero after restart");
	end

sync_outside_active: assert property (@(posedge clk50m_bufg) disable iff (reset)
		!(hsync_raw && active))
	else begin
		fail_count++;
		$error("hsync_raw overlaps the active window at hcount %0d", hcount);
	end

endmodule

bind raster_counter video_timing_assertions raster_checks (
	.clk50m_bufg (clk50m_bufg),
	.reset       (reset),
	.mode        (mode),
	.restart     (restart),
	.hcount      (hcount),
	.hsync_raw   (hsync_raw),
	.active      (active)
);

// File: sim/video_timing_tb.sv
`timescale 1ns/1ps

module video_timing_tb;

localparam int N_RANDOM = 12;    // Random mode picks
localparam int N_MODES = N_RANDOM + 2;
localparam int LINES_PER_MODE = 3;
localparam int MODE_LATENCY = 19;    // From sw edge to new synthesizer values
localparam logic [31:0] SEED = 32'h6155_bc03;

logic clk50m_bufg;
logic reset;
logic [1:0] sw;
logic [video_pkg::SYNTH_W-1:0] pclk_m;
logic [video_pkg::SYNTH_W-1:0] pclk_d;
logic hsync;
logic vsync;
logic de;
logic [video_pkg::COLOR_W-1:0] red;
logic [video_pkg::COLOR_W-1:0] green;
logic [video_pkg::COLOR_W-1:0] blue;

int error_count = 0;
int check_count = 0;
logic [31:0] rand_state = SEED;
int cur_mode = 0;    // Mode the model expects
logic [1:0] sw_code = 2'b00;

clock_gen clock_gen_0 (
	.clk50m_bufg (clk50m_bufg),
	.reset       (reset)
);

video_timing_top dut0 (
	.clk50m_bufg (clk50m_bufg),
	.reset       (reset),
	.sw          (sw),
	.pclk_m      (pclk_m),
	.pclk_d      (pclk_d),
	.hsync       (hsync),
	.vsync       (vsync),
	.de          (de),
	.red         (red),
	.green       (green),
	.blue        (blue)
);

////////////////////////////////////////
// Reference model
////////////////////////////////////////
function automatic logic [31:0] next_random(input logic [31:0] state);
	return state * 32'd1664525 + 32'd1013904223;
endfunction

function automatic int effective_mode(input logic [1:0] code);
	return (code == 2'd3) ? 0 : int'(code);    // Code 3 falls back to HMD
endfunction

function automatic int line_total(input int m);
	return video_pkg::HPIXELS[m] + video_pkg::HFPORCH[m] +
		video_pkg::HSYNCPW[m] + video_pkg::HBPORCH[m];
endfunction

function automatic logic [23:0] expected_pixel(input int m, input int pos);
	int idx;
	idx = pos / video_pkg::BAR_WIDTH[m];
	if (idx > 7) begin
		idx = 7;
	end
	return video_pkg::BAR_COLORS[idx];
endfunction

////////////////////////////////////////
// Checks
////////////////////////////////////////
task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("MISMATCH at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
	end
endtask

task automatic check_synth(input int m);
	check_value("pclk_m", video_pkg::SYNTH_M[m], pclk_m);
	check_value("pclk_d", video_pkg::SYNTH_D[m], pclk_d);
endtask

task automatic print_counts;
	$display("Checks: %0d, mismatches: %0d, assertion failures: %0d", check_count,
		error_count, dut0.raster_counter_0.raster_checks.fail_count);
endtask

// Returns at the falling clock edge where de is first seen high
task automatic wait_de_rise;
	logic prev;
	prev = de;
	@(negedge clk50m_bufg);
	while (!(de && !prev)) begin
		prev = de;
		@(negedge clk50m_bufg);
	end
endtask

// Starts at a de rise and ends at the de rise after the last line
task automatic check_lines(input int n_lines);
	int n;
	for (int line = 0; line < n_lines; line++) begin
		n = 0;
		while (de) begin
			check_value("pixel", expected_pixel(cur_mode, n), {red, green, blue});
			check_value("vsync", 1'b0, vsync);
			n++;
			@(negedge clk50m_bufg);
		end
		check_value("de high cycles", video_pkg::HPIXELS[cur_mode], n);
		n = 0;
		while (!hsync) begin
			check_value("vsync", 1'b0, vsync);
			n++;
			@(negedge clk50m_bufg);
		end
		check_value("front porch cycles", video_pkg::HFPORCH[cur_mode], n);
		n = 0;
		while (hsync) begin
			check_value("de", 1'b0, de);
			n++;
			@(negedge clk50m_bufg);
		end
		check_value("hsync high cycles", video_pkg::HSYNCPW[cur_mode], n);
		n = 0;
		while (!de) begin
			check_value("vsync", 1'b0, vsync);
			n++;
			@(negedge clk50m_bufg);
		end
		check_value("back porch cycles", video_pkg::HBPORCH[cur_mode], n);
	end
endtask

////////////////////////////////////////
// Stimulus
////////////////////////////////////////
task automatic apply_glitch(input logic [1:0] code, input int len);
	@(posedge clk50m_bufg);
	sw <= code;
	repeat (len) @(posedge clk50m_bufg);
	sw <= sw_code;
	repeat (len + video_pkg::DEBOUNCE_CYCLES + 8) begin
		@(negedge clk50m_bufg);
		check_synth(cur_mode);    // Glitch must not reach the mode
	end
endtask

task automatic apply_mode(input logic [1:0] code);
	int next_mode;
	next_mode = effective_mode(code);
	@(posedge clk50m_bufg);
	sw <= code;
	for (int k = 0; k <= MODE_LATENCY; k++) begin
		@(negedge clk50m_bufg);
		check_synth((k < MODE_LATENCY) ? cur_mode : next_mode);
	end
	cur_mode = next_mode;
	sw_code = code;
	repeat (2) @(negedge clk50m_bufg);    // Skip the cycle with mixed timing
endtask

initial begin
	logic [1:0] code;
	logic [1:0] glitch_code;
	int glitch_len;
	sw = 2'b00;
	wait (reset === 1'b0);
	@(negedge clk50m_bufg);
	check_value("pclk_m", 8'd180, pclk_m);
	check_value("pclk_d", 8'd84, pclk_d);
	check_value("de", 1'b0, de);
	check_value("hsync", 1'b0, hsync);
	check_value("vsync", 1'b0, vsync);
	check_value("pixel", 24'h0, {red, green, blue});
	wait_de_rise();
	check_value("first pixel", 24'hC0C0C0, {red, green, blue});    // White bar
	check_lines(LINES_PER_MODE);
	for (int i = 0; i < N_MODES; i++) begin
		rand_state = next_random(rand_state);
		glitch_len = 1 + int'(rand_state[27:24]) % 15;
		glitch_code = rand_state[21:20];
		if (effective_mode(glitch_code) == cur_mode) begin
			glitch_code = 2'(cur_mode) ^ 2'b01;
		end
		apply_glitch(glitch_code, glitch_len);
		if (i < N_RANDOM) begin
			code = rand_state[31:30];
		end else begin
			code = (i == N_RANDOM) ? 2'd1 : 2'd3;    // Code 3 coming from XGA
		end
		apply_mode(code);
		wait_de_rise();
		check_lines(LINES_PER_MODE);
	end
	print_counts();
	if (error_count == 0 && dut0.raster_counter_0.raster_checks.fail_count == 0) begin
		$display("TESTBENCH PASSED");
	end else begin
		$display("TESTBENCH FAILED");
	end
	$finish;
end

////////////////////////////////////////
// Watchdog
////////////////////////////////////////
initial begin
	int limit;
	int line_max;
	line_max = 0;
	for (int m = 0; m < 4; m++) begin
		if (line_total(m) > line_max) begin
			line_max = line_total(m);
		end
	end
	// Extra lines per mode cover the glitch and the wait for a line start
	limit = N_MODES * (MODE_LATENCY + LINES_PER_MODE * line_max) +
		(N_MODES + 1) * (2 * line_max + 64);
	repeat (limit) @(posedge clk50m_bufg);
	$display("The run did not finish within %0d clock cycles", limit);
	print_counts();
	$display("TESTBENCH FAILED");
	$finish;
end

endmodule

// File: video_timing_top.f
design/video_pkg.sv
design/mode_select.sv
design/raster_counter.sv
design/sync_gen.sv
design/color_bar_gen.sv
design/video_timing_top.sv
sim/clock_gen.sv
sim/video_timing_assertions.sv
sim/video_timing_tb.sv
